//--- src.f
+incdir+src
src/bank_isu_pkg.sv
src/bank_isu_issue_queue.sv
src/bank_isu_channel_credit.sv
src/bank_isu_credit_manage.sv
src/bank_isu_top.sv
bench/bank_isu_clkgen.sv
bench/bank_isu_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --timescale 1ns/1ps --top-module bank_isu_tb -f src.f \
  && ./obj_dir/Vbank_isu_tb | tee /dev/stderr | grep -qF "PASS: all tests" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- bench/bank_isu_tb.sv
`timescale 1ns/1ps
`include "bank_isu_cfg.svh"

module bank_isu_tb
  import bank_isu_pkg::*;
();

  // The random test takes about 600 cycles and the directed tests far fewer
  localparam int MAX_CYCLES  = 4000;
  localparam int RANDOM_REQS = 200;

  logic       clk;
  logic       rst;
  logic       enq_valid;
  logic       enq_is_read;
  ch_id_t     enq_ch_id;
  bank_addr_t enq_addr;
  logic       enq_full;
  logic       issue_ready;
  logic       issue_valid;
  logic       issue_is_read;
  ch_id_t     issue_ch_id;
  bank_addr_t issue_addr;
  ch_vec_t    credit_return;

  // Free credits per channel as the environment sees them
  int         credit_model [`BANK_ISU_CHANNEL_NUM];
  bank_addr_t issued_addr [$];
  int         cycle_count;

  // Fields of each request handed to the DUT, looked up by address when it issues
  logic       sent_is_read [bank_addr_t];
  ch_id_t     sent_ch_id [bank_addr_t];

  bank_isu_clkgen u_clkgen (.clk(clk));

  bank_isu_top dut (
    .clk           (clk),
    .rst           (rst),
    .enq_valid     (enq_valid),
    .enq_is_read   (enq_is_read),
    .enq_ch_id     (enq_ch_id),
    .enq_addr      (enq_addr),
    .enq_full      (enq_full),
    .issue_ready   (issue_ready),
    .issue_valid   (issue_valid),
    .issue_is_read (issue_is_read),
    .issue_ch_id   (issue_ch_id),
    .issue_addr    (issue_addr),
    .credit_return (credit_return)
  );

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped on the first error");
  endtask

  // ==============================
  // Monitor and timeout
  // ==============================

  // Outputs are stable at the falling edge and a handshake seen here completes at the next rise
  always @(negedge clk) begin
    if (!rst && issue_valid && issue_ready) begin
      assert (sent_is_read.exists(issue_addr)) else stop_with_error($sformatf(
        "MISMATCH at %0t: issued address %h was never enqueued", $time, issue_addr));
      assert (issue_is_read === sent_is_read[issue_addr]
              && issue_ch_id === sent_ch_id[issue_addr]) else stop_with_error($sformatf(
        "MISMATCH at %0t: %h issued as read %b channel %0d, enqueued as read %b channel %0d",
        $time, issue_addr, issue_is_read, issue_ch_id, sent_is_read[issue_addr],
        sent_ch_id[issue_addr]));
      if (issue_is_read) begin
        assert (credit_model[issue_ch_id] > 0) else stop_with_error($sformatf(
          "MISMATCH at %0t: read %h issued on channel %0d without a credit",
          $time, issue_addr, issue_ch_id));
        credit_model[issue_ch_id]--;
      end
      issued_addr.push_back(issue_addr);
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      stop_with_error($sformatf("Timeout after %0d cycles, the DUT stopped issuing", cycle_count));
    end
  end

  // ==============================
  // Drive helpers
  // ==============================
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic void record_request(input logic is_read, input ch_id_t ch,
                                         input bank_addr_t addr);
    sent_is_read[addr] = is_read;
    sent_ch_id[addr]   = ch;
  endfunction

  task automatic enqueue_one(input logic is_read, input ch_id_t ch, input bank_addr_t addr);
    enq_valid   = 1'b1;
    enq_is_read = is_read;
    enq_ch_id   = ch;
    enq_addr    = addr;
    record_request(is_read, ch, addr);
    next_cycle();
    enq_valid   = 1'b0;
  endtask

  // Channels whose credits were consumed by issued reads and not yet given back
  function automatic ch_vec_t outstanding_mask();
    ch_vec_t mask;
    mask = '0;
    for (int c = 0; c < `BANK_ISU_CHANNEL_NUM; c++) begin
      mask[c] = (credit_model[c] < `BANK_ISU_CREDIT_MAX);
    end
    return mask;
  endfunction

  task automatic give_back(input ch_vec_t mask);
    for (int c = 0; c < `BANK_ISU_CHANNEL_NUM; c++) begin
      if (mask[c]) begin
        credit_model[c]++;
      end
    end
    credit_return = mask;
    next_cycle();
    credit_return = '0;
  endtask

  task automatic wait_for_issues(input int total);
    while (issued_addr.size() < total) begin
      next_cycle();
    end
  endtask

  task automatic expect_issue_count(input int total);
    repeat (4) next_cycle();
    assert (issued_addr.size() == total) else stop_with_error($sformatf(
      "MISMATCH at %0t: %0d issues seen, %0d expected", $time, issued_addr.size(), total));
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic write_needs_no_credit();
    int base;
    base = issued_addr.size();
    issue_ready = 1'b1;
    enqueue_one(1'b0, ch_id_t'(1), 16'h0101);
    assert (issue_valid === 1'b1 && issue_addr === 16'h0101) else stop_with_error($sformatf(
      "MISMATCH at %0t: write not presented, valid %b addr %h", $time, issue_valid, issue_addr));
    wait_for_issues(base + 1);
    assert (outstanding_mask() == '0) else stop_with_error($sformatf(
      "MISMATCH at %0t: a write changed the credit model", $time));
  endtask

  task automatic read_credit_limit();
    int base;
    base = issued_addr.size();
    issue_ready = 1'b0;
    for (int i = 0; i <= `BANK_ISU_CREDIT_MAX; i++) begin
      enqueue_one(1'b1, ch_id_t'(0), bank_addr_t'(16'h0200 + i));
    end
    issue_ready = 1'b1;
    wait_for_issues(base + `BANK_ISU_CREDIT_MAX);
    expect_issue_count(base + `BANK_ISU_CREDIT_MAX);
    give_back(3'b001);
    wait_for_issues(base + `BANK_ISU_CREDIT_MAX + 1);
    assert (issued_addr[$] == bank_addr_t'(16'h0200 + `BANK_ISU_CREDIT_MAX)) else
      stop_with_error($sformatf("MISMATCH at %0t: extra read issued as %h", $time, issued_addr[$]));
    repeat (`BANK_ISU_CREDIT_MAX) give_back(outstanding_mask());
  endtask

  task automatic channels_independent();
    int base;
    base = issued_addr.size();
    issue_ready = 1'b1;
    for (int i = 0; i < `BANK_ISU_CREDIT_MAX; i++) begin
      enqueue_one(1'b1, ch_id_t'(0), bank_addr_t'(16'h0300 + i));
    end
    wait_for_issues(base + `BANK_ISU_CREDIT_MAX);
    // Channel 0 is out of credits now, so this read has to wait
    enqueue_one(1'b1, ch_id_t'(0), 16'h0310);
    enqueue_one(1'b1, ch_id_t'(1), 16'h0311);
    wait_for_issues(base + `BANK_ISU_CREDIT_MAX + 1);
    assert (issued_addr[$] == 16'h0311) else stop_with_error($sformatf(
      "MISMATCH at %0t: channel 1 read blocked, got %h", $time, issued_addr[$]));
    expect_issue_count(base + `BANK_ISU_CREDIT_MAX + 1);
    give_back(3'b001);
    wait_for_issues(base + `BANK_ISU_CREDIT_MAX + 2);
    assert (issued_addr[$] == 16'h0310) else stop_with_error($sformatf(
      "MISMATCH at %0t: waiting read issued as %h", $time, issued_addr[$]));
    repeat (`BANK_ISU_CREDIT_MAX) give_back(outstanding_mask());
  endtask

  task automatic full_queue_drop();
    int base;
    base = issued_addr.size();
    issue_ready = 1'b0;
    for (int i = 0; i < `BANK_ISU_DEPTH; i++) begin
      assert (enq_full === 1'b0) else stop_with_error($sformatf(
        "MISMATCH at %0t: full raised after %0d entries", $time, i));
      enqueue_one(1'b0, ch_id_t'(i % `BANK_ISU_CHANNEL_NUM), bank_addr_t'(16'h0400 + i));
    end
    assert (enq_full === 1'b1) else stop_with_error($sformatf(
      "MISMATCH at %0t: full not raised with every entry valid", $time));
    enqueue_one(1'b0, ch_id_t'(0), 16'h04ff);
    issue_ready = 1'b1;
    wait_for_issues(base + `BANK_ISU_DEPTH);
    expect_issue_count(base + `BANK_ISU_DEPTH);
    for (int i = base; i < issued_addr.size(); i++) begin
      assert (issued_addr[i] != 16'h04ff) else stop_with_error($sformatf(
        "MISMATCH at %0t: enqueue while full was accepted", $time));
    end
  endtask

  task automatic random_traffic();
    bank_addr_t expected [$];
    ch_vec_t    rand_mask;
    int         base;
    int         hits;
    base = issued_addr.size();
    while (expected.size() < RANDOM_REQS) begin
      if (!enq_full && $urandom_range(1, 0) == 1) begin
        enq_valid   = 1'b1;
        enq_is_read = ($urandom_range(1, 0) == 1);
        enq_ch_id   = ch_id_t'($urandom_range(`BANK_ISU_CHANNEL_NUM - 1, 0));
        enq_addr    = bank_addr_t'(16'h8000 + expected.size());
        record_request(enq_is_read, enq_ch_id, enq_addr);
        expected.push_back(enq_addr);
      end
      issue_ready = ($urandom_range(3, 0) != 0);
      for (int c = 0; c < `BANK_ISU_CHANNEL_NUM; c++) begin
        rand_mask[c] = ($urandom_range(3, 0) == 0);
      end
      give_back(outstanding_mask() & rand_mask);
      enq_valid = 1'b0;
    end
    issue_ready = 1'b1;
    while (issued_addr.size() < base + expected.size()) begin
      give_back(outstanding_mask());
    end
    expect_issue_count(base + expected.size());
    foreach (expected[k]) begin
      hits = 0;
      for (int i = base; i < issued_addr.size(); i++) begin
        hits += (issued_addr[i] == expected[k]) ? 1 : 0;
      end
      assert (hits == 1) else stop_with_error($sformatf(
        "MISMATCH at %0t: address %h issued %0d times", $time, expected[k], hits));
    end
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    rst           = 1'b1;
    enq_valid     = 1'b0;
    enq_is_read   = 1'b0;
    enq_ch_id     = '0;
    enq_addr      = '0;
    issue_ready   = 1'b0;
    credit_return = '0;
    cycle_count   = 0;
    for (int c = 0; c < `BANK_ISU_CHANNEL_NUM; c++) begin
      credit_model[c] = `BANK_ISU_CREDIT_MAX;
    end
    void'($urandom(32'h88956fde));
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    write_needs_no_credit();
    read_credit_limit();
    channels_independent();
    full_queue_drop();
    random_traffic();
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- bench/bank_isu_clkgen.sv
`timescale 1ns/1ps

module bank_isu_clkgen #(
  parameter int HALF_PERIOD_NS = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

endmodule

//--- src/bank_isu_top.sv
`timescale 1ns/1ps
`include "bank_isu_cfg.svh"

module bank_isu_top
  import bank_isu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  input  logic       enq_valid,
  input  logic       enq_is_read,
  input  ch_id_t     enq_ch_id,
  input  bank_addr_t enq_addr,
  output logic       enq_full,

  input  logic       issue_ready,
  output logic       issue_valid,
  output logic       issue_is_read,
  output ch_id_t     issue_ch_id,
  output bank_addr_t issue_addr,

  input  ch_vec_t    credit_return
);

  // ==============================
  // Internal wiring
  // ==============================
  logic    iq_enqueue;
  iq_ptr_t iq_write_ptr;
  iq_vec_t iq_valid_array;
  ch_id_t  ch_id_array [`BANK_ISU_DEPTH];
  iq_vec_t credit_allow_array;
  ch_vec_t enq_take;
  ch_vec_t enq_defer;
  ch_vec_t late_grant;
  ch_vec_t has_credit;
  ch_vec_t has_pending;

  bank_isu_issue_queue u_issue_queue (
    .clk                (clk),
    .rst                (rst),
    .enq_valid          (enq_valid),
    .enq_is_read        (enq_is_read),
    .enq_ch_id          (enq_ch_id),
    .enq_addr           (enq_addr),
    .enq_full           (enq_full),
    .iq_enqueue         (iq_enqueue),
    .iq_write_ptr       (iq_write_ptr),
    .iq_valid_array     (iq_valid_array),
    .ch_id_array        (ch_id_array),
    .credit_allow_array (credit_allow_array),
    .issue_ready        (issue_ready),
    .issue_valid        (issue_valid),
    .issue_is_read      (issue_is_read),
    .issue_ch_id        (issue_ch_id),
    .issue_addr         (issue_addr)
  );

  // Request fields go straight from the enqueue port to the credit decision
  bank_isu_credit_manage u_credit_manage (
    .clk                (clk),
    .rst                (rst),
    .iq_enqueue         (iq_enqueue),
    .iq_write_ptr       (iq_write_ptr),
    .htu_op_is_read     (enq_is_read),
    .htu_ch_id          (enq_ch_id),
    .iq_valid_array     (iq_valid_array),
    .ch_id_array        (ch_id_array),
    .has_credit         (has_credit),
    .has_pending        (has_pending),
    .credit_allow_array (credit_allow_array),
    .enq_take           (enq_take),
    .enq_defer          (enq_defer),
    .late_grant         (late_grant)
  );

  bank_isu_channel_credit u_channel_credit (
    .clk           (clk),
    .rst           (rst),
    .enq_take      (enq_take),
    .late_grant    (late_grant),
    .enq_defer     (enq_defer),
    .credit_return (credit_return),
    .has_credit    (has_credit),
    .has_pending   (has_pending)
  );

endmodule

//--- src/bank_isu_credit_manage.sv
`timescale 1ns/1ps
`include "bank_isu_cfg.svh"

module bank_isu_credit_manage
  import bank_isu_pkg::*;
(
  input  logic    clk,
  input  logic    rst,

  // Enqueue from the queue and the request fields
  input  logic    iq_enqueue,
  input  iq_ptr_t iq_write_ptr,
  input  logic    htu_op_is_read,
  input  ch_id_t  htu_ch_id,

  // Entry state
  input  iq_vec_t iq_valid_array,
  input  ch_id_t  ch_id_array [`BANK_ISU_DEPTH],

  // Channel status
  input  ch_vec_t has_credit,
  input  ch_vec_t has_pending,

  output iq_vec_t credit_allow_array,
  output ch_vec_t enq_take,
  output ch_vec_t enq_defer,
  output ch_vec_t late_grant
);

  iq_vec_t allow_q;
  iq_vec_t allow_d;
  iq_vec_t waiting;
  iq_vec_t grant_set;
  iq_vec_t ch_waiting [`BANK_ISU_CHANNEL_NUM];
  iq_vec_t ch_grant [`BANK_ISU_CHANNEL_NUM];
  ch_vec_t enq_ch_sel;
  logic    enq_read;
  logic    enq_has_credit;

  // ==============================
  // Credit at enqueue
  // ==============================
  always_comb begin
    for (int c = 0; c < `BANK_ISU_CHANNEL_NUM; c++) begin
      enq_ch_sel[c] = (htu_ch_id == ch_id_t'(c));
    end
  end

  // A read may only take a credit if no older read of its channel is waiting,
  // otherwise it would overtake that read
  assign enq_read       = iq_enqueue & htu_op_is_read;
  assign enq_has_credit = ~htu_op_is_read | (|(enq_ch_sel & has_credit & ~has_pending));

  assign enq_take  = (enq_read && enq_has_credit)  ? enq_ch_sel : '0;
  assign enq_defer = (enq_read && !enq_has_credit) ? enq_ch_sel : '0;

  // ==============================
  // Deferred grant
  // ==============================

  // Valid entries without a credit are always reads
  assign waiting = iq_valid_array & ~allow_q;

  always_comb begin
    grant_set = '0;
    for (int c = 0; c < `BANK_ISU_CHANNEL_NUM; c++) begin
      for (int i = 0; i < `BANK_ISU_DEPTH; i++) begin
        ch_waiting[c][i] = waiting[i] && (ch_id_array[i] == ch_id_t'(c));
      end
      // Two's complement trick isolates the lowest waiting entry
      ch_grant[c]   = has_credit[c] ? (ch_waiting[c] & (~ch_waiting[c] + iq_vec_t'(1))) : '0;
      late_grant[c] = |ch_grant[c];
      grant_set     = grant_set | ch_grant[c];
    end
  end

  // ==============================
  // Allow bits
  // ==============================
  always_comb begin
    allow_d = allow_q | grant_set;
    // The write slot is free, so a grant never targets it in the same cycle
    if (iq_enqueue) begin
      allow_d[iq_write_ptr] = enq_has_credit;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      allow_q <= '0;
    end else begin
      allow_q <= allow_d;
    end
  end

  assign credit_allow_array = allow_q;

endmodule

//--- src/bank_isu_channel_credit.sv
`timescale 1ns/1ps
`include "bank_isu_cfg.svh"

module bank_isu_channel_credit
  import bank_isu_pkg::*;
(
  input  logic    clk,
  input  logic    rst,

  // Credit consumers
  input  ch_vec_t enq_take,
  input  ch_vec_t late_grant,

  // Reads that entered the queue without a credit
  input  ch_vec_t enq_defer,

  // Credits given back by the response buffers
  input  ch_vec_t credit_return,

  output ch_vec_t has_credit,
  output ch_vec_t has_pending
);

  // ==============================
  // Per-channel counters
  // ==============================
  for (genvar c = 0; c < `BANK_ISU_CHANNEL_NUM; c++) begin : g_ch

    credit_cnt_t credit_q;
    pend_cnt_t   pend_q;
    logic        credit_used;

    // A channel never sees a take and a late grant in one cycle, since a take
    // needs an empty waiting count and a late grant needs a waiting read
    assign credit_used = enq_take[c] | late_grant[c];

    // Free credits where a use and a return in the same cycle cancel out
    always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
        credit_q <= credit_cnt_t'(`BANK_ISU_CREDIT_MAX);
      end else begin
        if (credit_used && !credit_return[c]) begin
          credit_q <= credit_q - credit_cnt_t'(1);
        end else if (credit_return[c] && !credit_used) begin
          credit_q <= credit_q + credit_cnt_t'(1);
        end
      end
    end

    // Reads in the queue that still wait for a credit
    always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
        pend_q <= '0;
      end else begin
        if (enq_defer[c] && !late_grant[c]) begin
          pend_q <= pend_q + pend_cnt_t'(1);
        end else if (late_grant[c] && !enq_defer[c]) begin
          pend_q <= pend_q - pend_cnt_t'(1);
        end
      end
    end

    assign has_credit[c]  = (credit_q != '0);
    assign has_pending[c] = (pend_q != '0);

  end

endmodule

//--- src/bank_isu_issue_queue.sv
`timescale 1ns/1ps
`include "bank_isu_cfg.svh"

module bank_isu_issue_queue
  import bank_isu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  // Enqueue side
  input  logic       enq_valid,
  input  logic       enq_is_read,
  input  ch_id_t     enq_ch_id,
  input  bank_addr_t enq_addr,
  output logic       enq_full,

  // Entry state towards the credit logic
  output logic       iq_enqueue,
  output iq_ptr_t    iq_write_ptr,
  output iq_vec_t    iq_valid_array,
  output ch_id_t     ch_id_array [`BANK_ISU_DEPTH],
  input  iq_vec_t    credit_allow_array,

  // Issue side
  input  logic       issue_ready,
  output logic       issue_valid,
  output logic       issue_is_read,
  output ch_id_t     issue_ch_id,
  output bank_addr_t issue_addr
);

  // ==============================
  // Entry storage
  // ==============================
  iq_vec_t    valid_q;
  iq_vec_t    is_read_q;
  ch_id_t     ch_id_q [`BANK_ISU_DEPTH];
  bank_addr_t addr_q [`BANK_ISU_DEPTH];

  iq_vec_t    issue_cand;
  iq_ptr_t    issue_ptr;
  logic       issue_fire;

  // Returns the index of the lowest set bit, or zero when no bit is set
  function automatic iq_ptr_t lowest_index(input iq_vec_t vec);
    iq_ptr_t idx;
    idx = '0;
    for (int i = `BANK_ISU_DEPTH - 1; i >= 0; i--) begin
      if (vec[i]) begin
        idx = iq_ptr_t'(i);
      end
    end
    return idx;
  endfunction

  // ==============================
  // Allocation
  // ==============================

  // The queue is full once every entry holds a request
  assign enq_full     = &valid_q;
  assign iq_enqueue   = enq_valid & ~enq_full;
  assign iq_write_ptr = lowest_index(~valid_q);

  // ==============================
  // Issue selection
  // ==============================

  // Only entries that own a credit (or are writes) may leave the queue
  assign issue_cand    = valid_q & credit_allow_array;
  assign issue_valid   = |issue_cand;
  assign issue_ptr     = lowest_index(issue_cand);
  assign issue_fire    = issue_valid & issue_ready;

  assign issue_is_read = is_read_q[issue_ptr];
  assign issue_ch_id   = ch_id_q[issue_ptr];
  assign issue_addr    = addr_q[issue_ptr];

  // ==============================
  // Entry update
  // ==============================
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      // The write slot is always free, so it never collides with the issued slot
      if (issue_fire) begin
        valid_q[issue_ptr] <= 1'b0;
      end
      if (iq_enqueue) begin
        valid_q[iq_write_ptr] <= 1'b1;
      end
    end
  end

  // Request fields land in the slot being allocated
  always_ff @(posedge clk) begin
    if (iq_enqueue) begin
      is_read_q[iq_write_ptr] <= enq_is_read;
      ch_id_q[iq_write_ptr]   <= enq_ch_id;
      addr_q[iq_write_ptr]    <= enq_addr;
    end
  end

  assign iq_valid_array = valid_q;
  assign ch_id_array    = ch_id_q;

endmodule

//--- src/bank_isu_pkg.sv
`include "bank_isu_cfg.svh"

package bank_isu_pkg;

  // Index of one issue queue entry
  typedef logic [`BANK_ISU_PTR_WIDTH-1:0] iq_ptr_t;

  // One bit per issue queue entry
  typedef logic [`BANK_ISU_DEPTH-1:0] iq_vec_t;

  // Channel number and one bit per channel
  typedef logic [1:0] ch_id_t;
  typedef logic [`BANK_ISU_CHANNEL_NUM-1:0] ch_vec_t;

  // Free response-buffer credits of one channel from 0 up to CREDIT_MAX
  typedef logic [$clog2(`BANK_ISU_CREDIT_MAX+1)-1:0] credit_cnt_t;

  // Reads of one channel waiting for a credit can fill every entry
  typedef logic [`BANK_ISU_PTR_WIDTH:0] pend_cnt_t;

  typedef logic [`BANK_ISU_ADDR_WIDTH-1:0] bank_addr_t;

endpackage

//--- src/bank_isu_cfg.svh
`ifndef BANK_ISU_CFG_SVH
`define BANK_ISU_CFG_SVH

// ==============================
// Issue queue geometry
// ==============================
`define BANK_ISU_PTR_WIDTH 3
`define BANK_ISU_DEPTH (1 << `BANK_ISU_PTR_WIDTH)

// ==============================
// Channels and request format
// ==============================
`define BANK_ISU_CHANNEL_NUM 3
`define BANK_ISU_CREDIT_MAX 4
`define BANK_ISU_ADDR_WIDTH 16

`endif
